// ==== rtl/cpuPkg.sv ====
// cpu core package with the instruction set, select encodings and fixed addresses.
`default_nettype none

package cpuPkg;

  localparam int WORD_W   = 16;
  localparam int NUM_REGS = 8; // r0 is a normal register.

  localparam logic [WORD_W-1:0] RESET_PC   = 16'h0000;
  localparam logic [WORD_W-1:0] IRQ_VECTOR = 16'h0004;

  // bit positions in the flags vector.
  localparam int FLAG_Z = 3;
  localparam int FLAG_N = 2;
  localparam int FLAG_C = 1;
  localparam int FLAG_V = 0;

  // write-back source.
  localparam logic [1:0] WD_ALU = 2'd0;
  localparam logic [1:0] WD_MEM = 2'd1;
  localparam logic [1:0] WD_PC  = 2'd2;

  // next pc source.
  localparam logic [1:0] PC_INC = 2'd0;
  localparam logic [1:0] PC_ALU = 2'd1;
  localparam logic [1:0] PC_LR  = 2'd2; // irr instead when irqSave is set.
  localparam logic [1:0] PC_VEC = 2'd3;

  localparam logic OP1_RS1  = 1'b0;
  localparam logic OP1_PC   = 1'b1;
  localparam logic OP2_REG  = 1'b0;
  localparam logic OP2_IMM  = 1'b1;
  localparam logic ADDR_PC  = 1'b0;
  localparam logic ADDR_RS1 = 1'b1;
  localparam logic OUT_ADDR = 1'b0;
  localparam logic OUT_DATA = 1'b1;

  typedef enum logic [3:0] {
    ALU_REG = 4'h0,
    ADDI    = 4'h1,
    LDI     = 4'h2,
    LD      = 4'h3,
    ST      = 4'h4,
    BCC     = 4'h5,
    BL      = 4'h6,
    RET     = 4'h7,
    RETI    = 4'h8,
    EI      = 4'h9,
    DI      = 4'ha
  } opcodeT;

  typedef enum logic [2:0] {ADD, SUB, AND, OR, XOR, SHL, SHR, PASS} aluFuncT;

  typedef enum logic [2:0] {ALWAYS, EQ, NE, CS, CC, MI, PL, VS} condT;

  typedef struct packed {
    opcodeT     op;
    logic [2:0] rd;
    logic [2:0] rs1;
    logic [2:0] rs2;
    aluFuncT    func;
  } regFormT;

  typedef struct packed {
    opcodeT            op;
    logic [2:0]        rd;  // condition code for BCC.
    logic signed [8:0] imm;
  } immFormT;

  typedef union packed {
    regFormT regForm;
    immFormT immForm;
  } instrT;

endpackage

`default_nettype wire

// ==== rtl/cpuAlu.sv ====
// cpu ALU computing the selected function and its Z, N, C, V flags.
`timescale 1ns/1ns
`default_nettype none

module cpuAlu import cpuPkg::*; (
  input  wire logic [WORD_W-1:0] a,
  input  wire logic [WORD_W-1:0] b,
  input  wire aluFuncT           func,
  output logic [WORD_W-1:0]      result,
  output logic [3:0]             flagsOut
);

  logic [WORD_W:0] sumWide;
  logic [WORD_W:0] shlWide;
  logic [WORD_W:0] shrWide;
  logic            carry;
  logic            overflow;

  assign shlWide = {1'b0, a} << b[3:0]; // msb is the last bit out.
  assign shrWide = {a, 1'b0} >> b[3:0]; // lsb is the last bit out.

  always_comb begin
    sumWide  = '0;
    carry    = 1'b0;
    overflow = 1'b0;
    unique case (func)
      ADD: begin
        sumWide  = {1'b0, a} + {1'b0, b};
        result   = sumWide[WORD_W-1:0];
        carry    = sumWide[WORD_W];
        overflow = (a[WORD_W-1] == b[WORD_W-1]) && (result[WORD_W-1] != a[WORD_W-1]);
      end
      SUB: begin
        sumWide  = {1'b0, a} - {1'b0, b};
        result   = sumWide[WORD_W-1:0];
        carry    = sumWide[WORD_W]; // set on borrow.
        overflow = (a[WORD_W-1] != b[WORD_W-1]) && (result[WORD_W-1] != a[WORD_W-1]);
      end
      AND:  result = a & b;
      OR:   result = a | b;
      XOR:  result = a ^ b;
      SHL: begin
        result = shlWide[WORD_W-1:0];
        carry  = shlWide[WORD_W];
      end
      SHR: begin
        result = shrWide[WORD_W:1];
        carry  = shrWide[0];
      end
      PASS: result = b;
    endcase
  end

  assign flagsOut[FLAG_Z] = (result == '0);
  assign flagsOut[FLAG_N] = result[WORD_W-1];
  assign flagsOut[FLAG_C] = carry;
  assign flagsOut[FLAG_V] = overflow;

endmodule

`default_nettype wire

// ==== rtl/cpuDatapath.sv ====
// cpu datapath holding registers, pc, link and return registers, ir, flags and bus muxes.
`timescale 1ns/1ns
`default_nettype none

module cpuDatapath import cpuPkg::*; (
  input  wire logic              Clock,
  input  wire logic              rstN,
  input  wire logic [WORD_W-1:0] dataIn,
  input  wire aluFuncT           aluOp,
  input  wire logic              aluEn,
  input  wire logic              op1Sel,
  input  wire logic              op2Sel,
  input  wire logic              regWe,
  input  wire logic [1:0]        wdSel,
  input  wire logic [1:0]        pcSel,
  input  wire logic              pcWe,
  input  wire logic              lrWe,
  input  wire logic              irqSave,
  input  wire logic              irWe,
  input  wire logic              flagsWe,
  input  wire logic              addrSel,
  input  wire logic              busOutSel,
  output logic [WORD_W-1:0]      dataOut,
  output instrT                  instr,
  output logic [3:0]             flags
);

  logic [WORD_W-1:0] regs [NUM_REGS];
  logic [WORD_W-1:0] pc;
  logic [WORD_W-1:0] lr;
  logic [WORD_W-1:0] irr; // return address of the interrupted code.
  logic [WORD_W-1:0] rs1Val;
  logic [WORD_W-1:0] rs2Val;
  logic [WORD_W-1:0] rdVal;
  logic [WORD_W-1:0] immExt;
  logic [WORD_W-1:0] opA;
  logic [WORD_W-1:0] opB;
  logic [WORD_W-1:0] aluA;
  logic [WORD_W-1:0] aluB;
  logic [WORD_W-1:0] aluResult;
  logic [3:0]        aluFlags;
  logic [WORD_W-1:0] wrData;
  logic [WORD_W-1:0] pcNext;
  logic [WORD_W-1:0] busAddr;

  assign rs1Val = regs[instr.regForm.rs1];
  assign rs2Val = regs[instr.regForm.rs2];
  assign rdVal  = regs[instr.regForm.rd];
  assign immExt = {{(WORD_W-9){instr.immForm.imm[8]}}, instr.immForm.imm};

  // immediate form has no rs1, so the first register operand is rd there.
  assign opA = (op1Sel == OP1_PC) ? pc : ((op2Sel == OP2_IMM) ? rdVal : rs1Val);
  assign opB = (op2Sel == OP2_IMM) ? immExt : rs2Val;

  // operands held at zero while the ALU is idle.
  assign aluA = aluEn ? opA : '0;
  assign aluB = aluEn ? opB : '0;

  cpuAlu alu (
    .a        (aluA),
    .b        (aluB),
    .func     (aluOp),
    .result   (aluResult),
    .flagsOut (aluFlags)
  );

  always_comb begin
    unique case (wdSel)
      WD_MEM:  wrData = dataIn;
      WD_PC:   wrData = pc;
      default: wrData = aluResult;
    endcase
  end

  always_comb begin
    unique case (pcSel)
      PC_ALU:  pcNext = aluResult;
      PC_LR:   pcNext = irqSave ? irr : lr; // RETI takes the saved pc.
      PC_VEC:  pcNext = IRQ_VECTOR;
      default: pcNext = pc + 1'b1;
    endcase
  end

  assign busAddr = (addrSel == ADDR_RS1) ? rs1Val : pc;
  assign dataOut = (busOutSel == OUT_DATA) ? rdVal : busAddr;

  always_ff @(posedge Clock or negedge rstN) begin
    if (!rstN) begin
      pc    <= RESET_PC;
      flags <= '0;
    end else begin
      if (pcWe)
        pc <= pcNext;
      if (flagsWe)
        flags <= aluFlags;
    end
  end

  always_ff @(posedge Clock) begin
    if (regWe)
      regs[instr.regForm.rd] <= wrData;
    if (lrWe)
      lr <= pc; // pc already points past the call.
    if (irqSave && (pcSel != PC_LR))
      irr <= pc;
    if (irWe)
      instr <= dataIn;
  end

endmodule

`default_nettype wire

// ==== rtl/cpuControl.sv ====
// cpu control FSM sequencing bus cycles, decode, branch conditions and interrupt entry.
`timescale 1ns/1ns
`default_nettype none

module cpuControl import cpuPkg::*; (
  input  wire logic       Clock,
  input  wire logic       rstN,
  input  wire instrT      instr,
  input  wire logic [3:0] flags,
  input  wire logic       nWait,
  input  wire logic       nIRQ,
  output aluFuncT         aluOp,
  output logic            aluEn,
  output logic            op1Sel,
  output logic            op2Sel,
  output logic            regWe,
  output logic [1:0]      wdSel,
  output logic [1:0]      pcSel,
  output logic            pcWe,
  output logic            lrWe,
  output logic            irqSave,
  output logic            irWe,
  output logic            flagsWe,
  output logic            addrSel,
  output logic            busOutSel,
  output logic            ALE,
  output logic            nME,
  output logic            nOE,
  output logic            RnW,
  output logic            ENB
);

  typedef enum logic [2:0] {
    FETCH_ADDR, FETCH_ACC, EXECUTE, MEM_ADDR, MEM_ACC, IRQ_ENTRY
  } stateT;

  stateT  state;
  stateT  nextState;
  opcodeT op;
  condT   cond;
  logic   intEn;
  logic   intEnSet;
  logic   intEnClr;
  logic   running; // low for the idle cycle right after reset.
  logic   condTrue;
  logic   irqTake;

  assign op      = instr.regForm.op;
  assign cond    = condT'(instr.immForm.rd);
  assign irqTake = intEn && !nIRQ;

  always_comb begin
    unique case (cond)
      ALWAYS: condTrue = 1'b1;
      EQ:     condTrue = flags[FLAG_Z];
      NE:     condTrue = !flags[FLAG_Z];
      CS:     condTrue = flags[FLAG_C];
      CC:     condTrue = !flags[FLAG_C];
      MI:     condTrue = flags[FLAG_N];
      PL:     condTrue = !flags[FLAG_N];
      VS:     condTrue = flags[FLAG_V];
    endcase
  end

  always_comb begin
    nextState = state;
    aluOp     = ADD;
    aluEn     = 1'b0;
    op1Sel    = OP1_RS1;
    op2Sel    = OP2_REG;
    regWe     = 1'b0;
    wdSel     = WD_ALU;
    pcSel     = PC_INC;
    pcWe      = 1'b0;
    lrWe      = 1'b0;
    irqSave   = 1'b0;
    irWe      = 1'b0;
    flagsWe   = 1'b0;
    addrSel   = ADDR_PC;
    busOutSel = OUT_ADDR;
    ALE       = 1'b0;
    nME       = 1'b1;
    nOE       = 1'b1;
    RnW       = 1'b1;
    ENB       = 1'b0;
    intEnSet  = 1'b0;
    intEnClr  = 1'b0;
    unique case (state)
      FETCH_ADDR: begin
        if (running) begin
          ALE       = 1'b1;
          nextState = FETCH_ACC;
        end
      end
      FETCH_ACC: begin
        nME = 1'b0;
        nOE = 1'b0;
        if (nWait) begin
          irWe      = 1'b1;
          pcWe      = 1'b1; // pc steps to the next word.
          nextState = EXECUTE;
        end
      end
      EXECUTE: begin
        nextState = irqTake ? IRQ_ENTRY : FETCH_ADDR;
        unique case (op)
          ALU_REG: begin
            aluEn   = 1'b1;
            aluOp   = instr.regForm.func;
            regWe   = 1'b1;
            flagsWe = 1'b1;
          end
          ADDI: begin
            aluEn   = 1'b1;
            op2Sel  = OP2_IMM;
            regWe   = 1'b1;
            flagsWe = 1'b1;
          end
          LDI: begin
            aluEn  = 1'b1;
            aluOp  = PASS;
            op2Sel = OP2_IMM;
            regWe  = 1'b1;
          end
          LD, ST: nextState = MEM_ADDR;
          BCC, BL: begin
            aluEn  = 1'b1;
            op1Sel = OP1_PC;
            op2Sel = OP2_IMM;
            pcSel  = PC_ALU;
            pcWe   = (op == BL) || condTrue;
            lrWe   = (op == BL);
          end
          RET: begin
            pcSel = PC_LR;
            pcWe  = 1'b1;
          end
          RETI: begin
            pcSel    = PC_LR;
            irqSave  = 1'b1;
            pcWe     = 1'b1;
            intEnSet = 1'b1;
          end
          EI: intEnSet = 1'b1;
          DI: begin
            intEnClr  = 1'b1;
            nextState = FETCH_ADDR; // masked at its own boundary too.
          end
          default: ; // unused opcodes run as nop.
        endcase
      end
      MEM_ADDR: begin
        ALE       = 1'b1;
        addrSel   = ADDR_RS1;
        nextState = MEM_ACC;
      end
      MEM_ACC: begin
        nME     = 1'b0;
        addrSel = ADDR_RS1;
        if (op == ST) begin
          RnW       = 1'b0;
          ENB       = 1'b1;
          busOutSel = OUT_DATA;
        end else begin
          nOE = 1'b0;
        end
        if (nWait) begin
          regWe     = (op == LD);
          wdSel     = WD_MEM;
          nextState = irqTake ? IRQ_ENTRY : FETCH_ADDR;
        end
      end
      IRQ_ENTRY: begin
        irqSave   = 1'b1;
        pcSel     = PC_VEC;
        pcWe      = 1'b1;
        intEnClr  = 1'b1;
        nextState = FETCH_ADDR;
      end
      default: nextState = FETCH_ADDR;
    endcase
  end

  always_ff @(posedge Clock or negedge rstN) begin
    if (!rstN) begin
      state   <= FETCH_ADDR;
      intEn   <= 1'b0;
      running <= 1'b0;
    end else begin
      state   <= nextState;
      running <= 1'b1;
      if (intEnClr)
        intEn <= 1'b0;
      else if (intEnSet)
        intEn <= 1'b1;
    end
  end

endmodule

`default_nettype wire

// ==== rtl/cpuCore.sv ====
// cpu core top joining the control FSM and the datapath to the memory bus.
`timescale 1ns/1ns
`default_nettype none

module cpuCore import cpuPkg::*; (
  output wire logic [WORD_W-1:0] dataOut,
  output wire logic              ALE,
  output wire logic              nME,
  output wire logic              nOE,
  output wire logic              RnW,
  output wire logic              ENB,
  input  wire logic [WORD_W-1:0] dataIn,
  input  wire logic              nWait,
  input  wire logic              nIRQ,
  input  wire logic              Clock,
  input  wire logic              rstN
);

  wire aluFuncT    aluOp;
  wire logic       aluEn;
  wire logic       op1Sel;
  wire logic       op2Sel;
  wire logic       regWe;
  wire logic [1:0] wdSel;
  wire logic [1:0] pcSel;
  wire logic       pcWe;
  wire logic       lrWe;
  wire logic       irqSave;
  wire logic       irWe;
  wire logic       flagsWe;
  wire logic       addrSel;
  wire logic       busOutSel;
  wire instrT      instr;
  wire logic [3:0] flags;

  cpuControl control (
    .Clock     (Clock),
    .rstN      (rstN),
    .instr     (instr),     // from the datapath.
    .flags     (flags),
    .nWait     (nWait),
    .nIRQ      (nIRQ),
    .aluOp     (aluOp),
    .aluEn     (aluEn),
    .op1Sel    (op1Sel),
    .op2Sel    (op2Sel),
    .regWe     (regWe),
    .wdSel     (wdSel),
    .pcSel     (pcSel),
    .pcWe      (pcWe),
    .lrWe      (lrWe),
    .irqSave   (irqSave),
    .irWe      (irWe),
    .flagsWe   (flagsWe),
    .addrSel   (addrSel),
    .busOutSel (busOutSel),
    .ALE       (ALE),       // bus strobes.
    .nME       (nME),
    .nOE       (nOE),
    .RnW       (RnW),
    .ENB       (ENB)
  );

  cpuDatapath datapath (
    .Clock     (Clock),
    .rstN      (rstN),
    .dataIn    (dataIn),
    .aluOp     (aluOp),
    .aluEn     (aluEn),
    .op1Sel    (op1Sel),
    .op2Sel    (op2Sel),
    .regWe     (regWe),
    .wdSel     (wdSel),
    .pcSel     (pcSel),
    .pcWe      (pcWe),
    .lrWe      (lrWe),
    .irqSave   (irqSave),
    .irWe      (irWe),
    .flagsWe   (flagsWe),
    .addrSel   (addrSel),
    .busOutSel (busOutSel),
    .dataOut   (dataOut),   // address or store data.
    .instr     (instr),
    .flags     (flags)
  );

endmodule

`default_nettype wire

// ==== sim/busMemory.sv ====
// behavioural word memory for the cpu bus with random wait states and protocol checks.
`timescale 1ns/1ns
`default_nettype none

module busMemory (
  input  wire logic        Clock,
  input  wire logic        rstN,
  input  wire logic [15:0] busOut,
  input  wire logic        ALE,
  input  wire logic        nME,
  input  wire logic        nOE,
  input  wire logic        RnW,
  input  wire logic        ENB,
  output logic      [15:0] dataIn,
  output logic             nWait,
  output logic             busError
);

  logic [15:0] mem [65536];
  int          writeCount [65536];
  logic [15:0] addr;
  int          waitLeft;
  logic        prevAle;
  logic        inAccess;
  logic        holding; // last cycle was a wait cycle.
  logic [20:0] heldBus;
  wire  [20:0] busNow = {busOut, ALE, nME, nOE, RnW, ENB};

  task automatic failBus(input string why);
    $display("bus protocol error at %0t: %s", $time, why);
    busError = 1'b1;
  endtask

  initial begin
    for (int i = 0; i < 65536; i++) begin
      mem[i] = i[15:0] ^ 16'hC35A; // fill pattern.
      writeCount[i] = 0;
    end
    dataIn = '0;
    nWait = 1'b1;
    busError = 1'b0;
    addr = '0;
    waitLeft = 0;
    prevAle = 1'b0;
    inAccess = 1'b0;
    holding = 1'b0;
    heldBus = '0;
  end

  always @(posedge Clock) begin
    if (rstN) begin
      if (ALE && prevAle)
        failBus("ALE stayed high for more than one cycle");
      if (!nOE && !RnW)
        failBus("nOE and RnW were low at the same time");
      if (!nME && ((nOE == RnW) || (ENB == RnW)))
        failBus("nOE, RnW and ENB disagreed on the access direction");
      if (nME && (!nOE || !RnW || ENB))
        failBus("a read or write strobe was active outside an access phase");
      if (holding && (busNow != heldBus))
        failBus("bus outputs changed while nWait was low");
      if (!nME && !inAccess)
        failBus("access phase without a preceding address phase");
      if (ALE) begin
        addr = busOut;
        inAccess = 1'b1;
        waitLeft = $urandom % 4; // 0 to 3 wait cycles.
      end else if (!nME) begin
        if (nWait) begin
          if (!RnW) begin
            mem[addr] = busOut;
            writeCount[addr]++;
          end
          inAccess = 1'b0;
        end else begin
          waitLeft--;
        end
      end
      holding = !nME && !nWait;
      heldBus = busNow;
      prevAle = ALE;
      #1;
      nWait = (waitLeft == 0);
      dataIn = mem[addr];
    end
  end

endmodule

`default_nettype wire

// ==== sim/cpuCoreTb.sv ====
// testbench running a program on the cpu core and checking its result area.
`timescale 1ns/1ns
`default_nettype none

module cpuCoreTb import cpuPkg::*; ();

  logic        Clock;
  logic        rstN;
  logic        nIRQ;
  wire  [15:0] dataOut;
  wire  [15:0] dataIn;
  wire         ALE, nME, nOE, RnW, ENB, nWait, busError;

  logic [15:0] prog[$];
  logic [15:0] expAddr[$];
  logic [15:0] expData[$];
  logic [15:0] resultAddr;
  logic [15:0] setupOp [3];
  int          cycles;
  int          maxCycles;

  // per branch test the flag setup op, the condition and whether it branches.
  int   brSetup [15] = '{0, 0, 1, 1, 0, 1, 0, 0, 1, 1, 0, 0, 2, 2, 0};
  condT brCond  [15] = '{ALWAYS, EQ, EQ, NE, NE, CS, CS, CC, CC, MI, MI, PL, PL, VS, VS};
  bit   brTaken [15] = '{1, 1, 0, 1, 0, 1, 0, 1, 0, 1, 0, 1, 0, 1, 0};

  cpuCore DUT (
    .dataOut (dataOut),
    .ALE     (ALE),
    .nME     (nME),
    .nOE     (nOE),
    .RnW     (RnW),
    .ENB     (ENB),
    .dataIn  (dataIn),
    .nWait   (nWait),
    .nIRQ    (nIRQ),
    .Clock   (Clock),
    .rstN    (rstN)
  );

  busMemory memory (
    .Clock (Clock), .rstN (rstN), .busOut (dataOut), .ALE (ALE), .nME (nME),
    .nOE (nOE), .RnW (RnW), .ENB (ENB), .dataIn (dataIn), .nWait (nWait),
    .busError (busError)
  );

  function automatic logic [15:0] encR(opcodeT op, int rd, int rs1, int rs2, aluFuncT fn);
    return {op, rd[2:0], rs1[2:0], rs2[2:0], fn};
  endfunction

  function automatic logic [15:0] encI(opcodeT op, int rd, int imm);
    return {op, rd[2:0], imm[8:0]};
  endfunction

  task automatic emit(input logic [15:0] word);
    prog.push_back(word);
  endtask

  task automatic expectWord(input logic [15:0] a, input logic [15:0] d);
    expAddr.push_back(a);
    expData.push_back(d);
  endtask

  // store through r5 and step it to the next result slot.
  task automatic storeResult(input int rd, input logic [15:0] expected);
    emit(encR(ST, rd, 5, 0, ADD));
    emit(encI(ADDI, 5, 1));
    expectWord(resultAddr, expected);
    resultAddr++;
  endtask

  task automatic checkEqual(input logic [15:0] actual, input logic [15:0] expected,
                            input string what);
    if (actual !== expected) begin
      $display("ERROR %0t: %s is %h, expected %h", $time, what, actual, expected);
      $display("Test failed");
      $fatal(1);
    end
  endtask

  task automatic buildProgram();
    resultAddr = 16'hFF80;
    setupOp[0] = encR(ALU_REG, 4, 1, 1, SUB); // 5-5 zero.
    setupOp[1] = encR(ALU_REG, 4, 2, 1, SUB); // 3-5 negative with borrow.
    setupOp[2] = encR(ALU_REG, 4, 3, 0, ADD); // 7fff+1 overflow.
    emit(encI(BCC, ALWAYS, 7));
    repeat (3) emit(16'h0000);
    emit(encI(LDI, 7, 'h55)); // irq handler at the vector.
    emit(encI(LDI, 6, -160));
    emit(encR(ST, 7, 6, 0, ADD));
    emit(encR(RETI, 0, 0, 0, ADD));
    emit(encI(LDI, 5, -128));
    emit(encI(LDI, 0, 1));
    emit(encI(LDI, 1, 5));
    emit(encI(LDI, 2, 3));
    emit(encI(LDI, 3, -1));
    emit(encR(ALU_REG, 3, 3, 0, SHR));
    emit(encR(ALU_REG, 4, 1, 2, ADD));
    storeResult(4, 16'd5 + 16'd3);
    emit(encR(ALU_REG, 4, 2, 1, SUB));
    storeResult(4, 16'd3 - 16'd5);
    emit(encR(ALU_REG, 4, 1, 2, AND));
    storeResult(4, 16'd5 & 16'd3);
    emit(encR(ALU_REG, 4, 1, 2, OR));
    storeResult(4, 16'd5 | 16'd3);
    emit(encR(ALU_REG, 4, 1, 2, XOR));
    storeResult(4, 16'd5 ^ 16'd3);
    emit(encR(ALU_REG, 4, 1, 2, SHL));
    storeResult(4, 16'd5 << 3);
    emit(encR(ALU_REG, 4, 3, 2, SHR));
    storeResult(4, 16'h7FFF >> 3);
    emit(encI(LDI, 4, -100));
    storeResult(4, -16'sd100);
    emit(encI(ADDI, 4, 37));
    storeResult(4, -16'sd63);
    for (int k = 0; k < 15; k++) begin
      emit(setupOp[brSetup[k]]);
      emit(encI(LDI, 4, 'h20 + k));
      emit(encI(BCC, int'(brCond[k]), 1));
      emit(encI(LDI, 4, 'h40 + k));
      storeResult(4, brTaken[k] ? 16'h20 + k : 16'h40 + k);
    end
    emit(encI(LDI, 2, -176)); // store, load back, modify.
    emit(encI(LDI, 1, 123));
    emit(encR(ST, 1, 2, 0, ADD));
    emit(encR(LD, 3, 2, 0, ADD));
    emit(encI(ADDI, 3, 77));
    storeResult(3, 16'd200);
    emit(encI(LDI, 2, -192));
    emit(encR(LD, 4, 2, 0, ADD));
    emit(encI(ADDI, 4, 1));
    storeResult(4, (16'hFF40 ^ 16'hC35A) + 16'd1);
    emit(encI(BL, 0, 4));
    emit(encI(LDI, 4, 'h77));
    storeResult(4, 16'h0077);
    emit(encI(BCC, ALWAYS, 4));
    emit(encI(LDI, 4, 'h66));
    expAddr.insert(expAddr.size() - 1, resultAddr - 16'd1);
    expData.insert(expData.size() - 1, 16'h0066); // routine stores first.
    expAddr[expAddr.size() - 1] = resultAddr;
    resultAddr++;
    emit(encR(ST, 4, 5, 0, ADD));
    emit(encI(ADDI, 5, 1));
    emit(encR(RET, 0, 0, 0, ADD));
    emit(encR(EI, 0, 0, 0, ADD)); // DI below must clear it again.
    emit(encR(DI, 0, 0, 0, ADD));
    emit(encI(LDI, 4, 1));
    emit(encI(LDI, 2, -144));
    emit(encR(ST, 4, 2, 0, ADD));
    emit(encI(LDI, 1, 5));
    emit(encI(LDI, 3, 0));
    emit(encI(ADDI, 3, 1));
    emit(encI(ADDI, 1, -1));
    emit(encI(BCC, NE, -3));
    storeResult(3, 16'd5);
    emit(encI(LDI, 2, -143));
    emit(encR(ST, 4, 2, 0, ADD));
    emit(encR(EI, 0, 0, 0, ADD));
    emit(encI(LDI, 1, 6));
    emit(encI(LDI, 3, 0));
    emit(encI(ADDI, 3, 1));
    emit(encI(ADDI, 1, -1));
    emit(encI(BCC, NE, -3));
    storeResult(3, 16'd6);
    emit(encI(LDI, 1, 'hD0));
    emit(encI(LDI, 2, 8));
    emit(encR(ALU_REG, 1, 1, 2, SHL));
    emit(encI(ADDI, 1, 'hDE));
    emit(encI(LDI, 2, 'hFF));
    emit(encR(ST, 1, 2, 0, ADD));
    emit(encI(BCC, ALWAYS, -1)); // park here.
    expectWord(16'hFF50, 16'd123);
    expectWord(16'hFF60, 16'h0055);
    expectWord(16'hFF70, 16'h0001);
    expectWord(16'hFF71, 16'h0001);
    expectWord(16'h00FF, 16'hD0DE);
  endtask

  initial begin
    Clock = 1'b0;
    forever #5 Clock = ~Clock;
  end

  always @(posedge Clock) begin
    cycles++;
    if (cycles > maxCycles) begin
      $display("timeout: the program never finished within %0d cycles", maxCycles);
      $display("Test failed");
      $fatal(1);
    end
  end

  always @(posedge busError) begin
    $display("Test failed");
    $fatal(1);
  end

  initial begin
    void'($urandom(32'hb242));
    rstN = 1'b0;
    nIRQ = 1'b1;
    cycles = 0;
    buildProgram();
    maxCycles = (prog.size() + 40) * 5 * 4 + 200; // loops add about 40 instructions.
    @(posedge Clock);
    foreach (prog[i])
      memory.mem[i] = prog[i];
    repeat (2) @(posedge Clock);
    #1 rstN = 1'b1;
    while (memory.writeCount[16'hFF70] == 0) @(negedge Clock);
    @(posedge Clock);
    #1 nIRQ = 1'b0; // held low across the masked loop.
    while (memory.writeCount[16'hFF71] == 0) @(negedge Clock);
    checkEqual(16'(memory.writeCount[16'hFF60]), 16'd0, "handler runs while masked");
    while (memory.writeCount[16'hFF60] == 0) @(negedge Clock);
    @(posedge Clock);
    #1 nIRQ = 1'b1;
    while (memory.mem[16'h00FF] !== 16'hD0DE) @(negedge Clock);
    foreach (expAddr[i])
      checkEqual(memory.mem[expAddr[i]], expData[i], $sformatf("word at %h", expAddr[i]));
    checkEqual(16'(memory.writeCount[16'hFF60]), 16'd1, "handler run count");
    $display("Test passed");
    $finish;
  end

endmodule

`default_nettype wire

// ==== cpuSystem.f ====
rtl/cpuPkg.sv
rtl/cpuAlu.sv
rtl/cpuDatapath.sv
rtl/cpuControl.sv
rtl/cpuCore.sv
sim/busMemory.sv
sim/cpuCoreTb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       := cpuCoreTb
FILELIST  := cpuSystem.f
FLAGS     := --binary --timing -Wno-fatal
LINTFLAGS := --lint-only --timing
LOG       := sim.log
OBJDIR    := obj_dir

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)

run: build
	./$(OBJDIR)/V$(TOP) | tee $(LOG)
	@grep -q "^Test passed$$" $(LOG) || (echo "simulation did not pass" && exit 1)

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJDIR) $(LOG)
